// ==== camera_heading.f ====
source/image_pkg.sv
source/heading_pkg.sv
source/frame_buffer.sv
source/frame_scanner.sv
source/direction_detector.sv
source/camera_heading_top.sv
test/camera_heading_properties.sv
test/camera_heading_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the camera heading testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module camera_heading_tb -f camera_heading.f \
    -o camera_heading_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/camera_heading_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints the pass message on a line of its own
if grep -q "^No errors$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// ==== test/camera_heading_tb.sv ====
`default_nettype none

module camera_heading_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import image_pkg::*;
    import heading_pkg::*;

    localparam int SEED         = 48;
    localparam int NUM_FRAMES   = 24;  // Scans over all tests
    localparam int WRITE_CYCLES = PIXEL_COUNT + 2;
    localparam int CYCLE_LIMIT  = 2 * NUM_FRAMES * (PIXEL_COUNT + WRITE_CYCLES + 20);

    logic          clk;
    logic          arst_n;
    pixel_write_t  cam_write;
    logic          frame_ready;
    logic          scan_busy;
    frame_result_t result;
    logic          result_valid;
    overlay_beat_t overlay;

    rgb444_t       ref_mem [PIXEL_COUNT];  // Model copy of the frame buffer
    frame_result_t result_q[$];
    int num_checks = 0;
    int num_errors = 0;
    int test_checks = 0;
    int test_errors = 0;
    int cycle_count = 0;
    int beat_idx = 0;
    int ov_beats = 0;
    int ov_starts = 0;
    int ov_finishes = 0;
    int scans = 0;

    camera_heading_top u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .cam_write    (cam_write),
        .frame_ready  (frame_ready),
        .scan_busy    (scan_busy),
        .result       (result),
        .result_valid (result_valid),
        .overlay      (overlay)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    function automatic rgb444_t make_pixel(int r, int g, int b);
        rgb444_t p;
        p.red   = 4'(r);
        p.green = 4'(g);
        p.blue  = 4'(b);
        return p;
    endfunction

    function automatic logic pixel_is_red(rgb444_t p);
        int r;
        int g;
        int b;
        r = int'(p.red);
        g = int'(p.green);
        b = int'(p.blue);
        return (r > RED_THRESHOLD) && (g < r - RED_THRESHOLD) && (b < r - RED_THRESHOLD);
    endfunction

    function automatic frame_result_t model_result();
        frame_result_t res;
        int i;
        int count;
        int sum;
        int avg;
        count = 0;
        sum   = 0;
        for (i = 0; i < PIXEL_COUNT; i++) begin
            if (pixel_is_red(ref_mem[i])) begin
                count++;
                sum += i % IMAGE_WIDTH;
            end
        end
        avg = (count == 0) ? 0 : sum / count;
        res.heading   = HEADING_BITS'((FOV_DEGREES * avg) / (IMAGE_WIDTH - 1));
        res.no_red    = (count < MIN_RED_PIXELS);
        res.red_count = ADDR_BITS'(count);
        return res;
    endfunction

    function automatic overlay_beat_t model_overlay(int idx);
        overlay_beat_t beat;
        rgb444_t p;
        p = ref_mem[idx];
        beat.valid  = 1'b1;
        beat.start  = (idx == 0);
        beat.finish = (idx == PIXEL_COUNT - 1);
        beat.colour = '0;
        if (pixel_is_red(p)) begin
            beat.colour = {{p.red, p.red, 2'b00}, {p.green, p.green, 2'b00},
                           {p.blue, p.blue, 2'b00}};
        end
        return beat;
    endfunction

    task automatic check_result(input frame_result_t actual, input frame_result_t expected,
                                input string what);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("FAIL %0t: %s got heading %0d no_red %0b count %0d, expected %0d %0b %0d",
                     $time, what, actual.heading, actual.no_red, actual.red_count,
                     expected.heading, expected.no_red, expected.red_count);
        end
    endtask

    task automatic check_overlay(input overlay_beat_t actual, input overlay_beat_t expected,
                                 input int idx);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("FAIL %0t: overlay beat %0d got s%0b f%0b %h, expected s%0b f%0b %h",
                     $time, idx, actual.start, actual.finish, actual.colour,
                     expected.start, expected.finish, expected.colour);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_total(input int actual, input int expected, input string what);
        num_checks++;
        if (actual != expected) begin
            num_errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        if (arst_n) begin
            if (overlay.valid) begin
                check_overlay(overlay, model_overlay(beat_idx), beat_idx);
                ov_beats++;
                ov_starts   += int'(overlay.start);
                ov_finishes += int'(overlay.finish);
                beat_idx = (beat_idx == PIXEL_COUNT - 1) ? 0 : beat_idx + 1;
            end
            if (result_valid) begin
                result_q.push_back(result);
            end
        end
    end

    task automatic fill_non_red();
        int i;
        for (i = 0; i < PIXEL_COUNT; i++) begin
            ref_mem[i] = make_pixel($urandom_range(RED_THRESHOLD, 0), $urandom_range(15, 0),
                                    $urandom_range(15, 0));
        end
    endtask

    task automatic fill_random();
        int i;
        for (i = 0; i < PIXEL_COUNT; i++) begin
            ref_mem[i] = rgb444_t'(PIXEL_BITS'($urandom));
        end
    endtask

    // Strong red block on a dim background, the first two blocks below MIN_RED_PIXELS
    task automatic fill_block(input int k);
        int i;
        int col;
        int row;
        int col_lo;
        int row_lo;
        int width;
        int height;
        width  = (k == 0) ? 1 : (k == 1) ? 2 : int'($urandom_range(4, 1));
        height = (k == 0) ? 3 : (k == 1) ? 1 : int'($urandom_range(3, 1));
        col_lo = $urandom_range(IMAGE_WIDTH - width, 0);
        row_lo = $urandom_range(IMAGE_HEIGHT - height, 0);
        for (i = 0; i < PIXEL_COUNT; i++) begin
            col = i % IMAGE_WIDTH;
            row = i / IMAGE_WIDTH;
            if (col >= col_lo && col < col_lo + width && row >= row_lo && row < row_lo + height)
                ref_mem[i] = make_pixel($urandom_range(15, 12), $urandom_range(4, 0),
                                        $urandom_range(4, 0));
            else
                ref_mem[i] = make_pixel($urandom_range(2, 0), $urandom_range(2, 0),
                                        $urandom_range(2, 0));
        end
    endtask

    // Cycle through each threshold edge and the value one step inside it
    task automatic fill_edges();
        int i;
        int r;
        for (i = 0; i < PIXEL_COUNT; i++) begin
            r = $urandom_range(15, RED_THRESHOLD + 1);
            case (i % 6)
                0:       ref_mem[i] = make_pixel(RED_THRESHOLD, 0, 0);
                1:       ref_mem[i] = make_pixel(RED_THRESHOLD + 1, 0, 0);
                2:       ref_mem[i] = make_pixel(r, r - RED_THRESHOLD, 0);
                3:       ref_mem[i] = make_pixel(r, r - RED_THRESHOLD - 1, 0);
                4:       ref_mem[i] = make_pixel(r, 0, r - RED_THRESHOLD);
                default: ref_mem[i] = make_pixel(r, 0, r - RED_THRESHOLD - 1);
            endcase
        end
    endtask

    task automatic fill_mixed();
        int i;
        for (i = 0; i < PIXEL_COUNT; i++) begin
            if ($urandom_range(1, 0) == 1)
                ref_mem[i] = make_pixel($urandom_range(15, 10), $urandom_range(5, 0),
                                        $urandom_range(5, 0));
            else
                ref_mem[i] = rgb444_t'(PIXEL_BITS'($urandom));
        end
    endtask

    task automatic write_frame();
        int i;
        for (i = 0; i < PIXEL_COUNT; i++) begin
            @(posedge clk);
            cam_write <= '{strobe: 1'b1, addr: ADDR_BITS'(i), pixel: ref_mem[i]};
        end
        @(posedge clk);
        cam_write <= '0;
    endtask

    task automatic start_scan();
        @(posedge clk);
        frame_ready <= 1'b1;
        @(posedge clk);
        frame_ready <= 1'b0;
        scans++;
    endtask

    task automatic await_result(output frame_result_t res);
        while (result_q.size() == 0) @(negedge clk);
        res = result_q.pop_front();
    endtask

    task automatic run_frame(input string what);
        frame_result_t got;
        write_frame();
        start_scan();
        await_result(got);
        check_result(got, model_result(), what);
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d mismatches", num, name,
                 num_checks - test_checks, num_errors - test_errors);
        test_checks = num_checks;
        test_errors = num_errors;
    endtask

    initial begin
        frame_result_t got;
        frame_result_t again;
        int k;
        int beats_base;
        void'($urandom(SEED));
        arst_n      = 1'b0;
        cam_write   = '0;
        frame_ready = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag(scan_busy, 1'b0, "scan_busy after reset");
        check_flag(result_valid, 1'b0, "result_valid after reset");
        check_flag(overlay.valid, 1'b0, "overlay valid after reset");
        check_result(result, '0, "result after reset");

        for (k = 0; k < 2; k++) begin
            fill_non_red();
            write_frame();
            start_scan();
            await_result(got);
            check_result(got, '{heading: '0, no_red: 1'b1, red_count: '0}, "non-red frame");
        end
        finish_test(1, "non-red frames");

        for (k = 0; k < 6; k++) begin
            fill_random();
            run_frame("random frame");
        end
        finish_test(2, "random frames");

        for (k = 0; k < 6; k++) begin
            fill_block(k);
            run_frame("red block");
        end
        finish_test(3, "red blocks");

        for (k = 0; k < 2; k++) begin
            fill_edges();
            run_frame("threshold edges");
        end
        finish_test(4, "threshold edges");

        for (k = 0; k < 2; k++) begin
            beats_base = ov_beats;
            fill_mixed();
            run_frame("overlay frame");
            check_total(ov_beats - beats_base, PIXEL_COUNT, "overlay beats in frame");
            check_total(ov_starts, scans, "overlay start markers");
        end
        finish_test(5, "overlay stream");

        // Second scan starts while the first result is still in the pipeline
        for (k = 0; k < 3; k++) begin
            fill_mixed();
            write_frame();
            start_scan();
            while (!scan_busy) @(negedge clk);
            while (scan_busy) @(negedge clk);
            start_scan();
            await_result(got);
            await_result(again);
            check_result(got, model_result(), "first of back-to-back pair");
            check_result(again, model_result(), "second of back-to-back pair");
        end
        finish_test(6, "back-to-back frames");

        check_total(ov_finishes, scans, "overlay finish markers");
        check_total(beat_idx, 0, "overlay beats left over");
        $display("summary: 6 tests, %0d checks, %0d mismatches", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/camera_heading_properties.sv ====
`default_nettype none

module camera_heading_properties (
    input logic                       clk,
    input logic                       arst_n,
    input heading_pkg::frame_result_t result,
    input logic                       result_valid,
    input heading_pkg::overlay_beat_t overlay
);
    timeunit 1ns;
    timeprecision 1ps;

    import heading_pkg::*;

    // One result pulse per frame
    assert property (@(posedge clk) disable iff (!arst_n) result_valid |=> !result_valid)
        else $error("result_valid high for two cycles in a row");

    assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> (result.heading <= FOV_DEGREES))
        else $error("heading beyond the field of view");

    assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> (result.no_red == (result.red_count < MIN_RED_PIXELS)))
        else $error("no_red disagrees with red_count");

    // Frame markers only ride on a valid overlay beat
    assert property (@(posedge clk) disable iff (!arst_n)
        (overlay.start || overlay.finish) |-> overlay.valid)
        else $error("overlay start or finish without valid");

endmodule

bind direction_detector camera_heading_properties u_properties (
    .clk          (clk),
    .arst_n       (arst_n),
    .result       (result),
    .result_valid (result_valid),
    .overlay      (overlay)
);

`default_nettype wire

// ==== source/camera_heading_top.sv ====
`default_nettype none

module camera_heading_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  image_pkg::pixel_write_t    cam_write,
    input  logic                       frame_ready,
    output logic                       scan_busy,
    output heading_pkg::frame_result_t result,
    output logic                       result_valid,
    output heading_pkg::overlay_beat_t overlay
);

    import image_pkg::*;

    logic [ADDR_BITS-1:0] scan_addr;
    scan_tag_t            scan_tag;
    pixel_beat_t          pixel_beat;  // Read data with its aligned tag

    // Raster sweep of the stored frame
    frame_scanner u_scanner (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_ready (frame_ready),
        .scan_busy   (scan_busy),
        .scan_addr   (scan_addr),
        .scan_tag    (scan_tag)
    );

    frame_buffer u_buffer (
        .clk        (clk),
        .cam_write  (cam_write),
        .scan_addr  (scan_addr),
        .scan_tag   (scan_tag),
        .pixel_beat (pixel_beat)
    );

    // Red detection, heading and overlay
    direction_detector u_detector (
        .clk          (clk),
        .arst_n       (arst_n),
        .pixel_beat   (pixel_beat),
        .result       (result),
        .result_valid (result_valid),
        .overlay      (overlay)
    );

endmodule

`default_nettype wire

// ==== source/direction_detector.sv ====
`default_nettype none

module direction_detector (
    input  logic                       clk,
    input  logic                       arst_n,
    input  image_pkg::pixel_beat_t     pixel_beat,
    output heading_pkg::frame_result_t result,
    output logic                       result_valid,
    output heading_pkg::overlay_beat_t overlay
);

    import image_pkg::*;
    import heading_pkg::*;

    rgb444_t px;
    logic [3:0] red_margin;
    logic beat_valid;
    logic frame_end;
    logic is_red;

    logic [SUM_BITS-1:0]  col_sum;
    logic [ADDR_BITS-1:0] red_count;
    logic [SUM_BITS-1:0]  sum_next;
    logic [ADDR_BITS-1:0] count_next;

    logic                 s1_valid;
    logic [SUM_BITS-1:0]  s1_sum;
    logic [ADDR_BITS-1:0] s1_count;
    logic                 s2_valid;
    logic [COL_BITS-1:0]  s2_avg;
    logic [ADDR_BITS-1:0] s2_count;
    logic [HEADING_BITS-1:0] heading_next;

    logic ov_valid;
    logic ov_start;
    logic ov_finish;
    logic [2:0][9:0] ov_colour;

    assign px         = pixel_beat.pixel;
    assign beat_valid = pixel_beat.tag.valid;
    assign frame_end  = beat_valid && pixel_beat.tag.last;

    // Red must clear the threshold and lead green and blue by the same margin
    assign red_margin = px.red - 4'(RED_THRESHOLD);
    assign is_red = beat_valid && (px.red > 4'(RED_THRESHOLD))
                    && (px.green < red_margin) && (px.blue < red_margin);

    assign sum_next   = col_sum + (is_red ? SUM_BITS'(pixel_beat.tag.col) : '0);
    assign count_next = red_count + ADDR_BITS'(is_red);

    // Stage 1 takes the totals including the last beat and frees the accumulators
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_sum   <= '0;
            red_count <= '0;
            s1_valid  <= 1'b0;
        end else begin
            s1_valid <= frame_end;
            if (frame_end) begin
                col_sum   <= '0;
                red_count <= '0;
            end else if (beat_valid) begin
                col_sum   <= sum_next;
                red_count <= count_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end) begin
            s1_sum   <= sum_next;
            s1_count <= count_next;
        end
    end

    // Stage 2 average column
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_avg   <= (s1_count != '0) ? COL_BITS'(s1_sum / s1_count) : '0;
            s2_count <= s1_count;
        end
    end

    // Stage 3 scales the column onto the field of view
    assign heading_next = HEADING_BITS'((FOV_DEGREES * s2_avg) / (IMAGE_WIDTH - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= s2_valid;
            if (s2_valid) begin  // Held until the next frame completes
                result <= '{
                    heading:   heading_next,
                    no_red:    s2_count < MIN_RED_PIXELS,
                    red_count: s2_count
                };
            end
        end
    end

    // Overlay stream, one beat per scanned pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ov_valid  <= 1'b0;
            ov_start  <= 1'b0;
            ov_finish <= 1'b0;
        end else begin
            ov_valid  <= beat_valid;
            ov_start  <= beat_valid && pixel_beat.tag.first;
            ov_finish <= frame_end;
        end
    end

    always_ff @(posedge clk) begin
        if (is_red) begin
            ov_colour <= {{px.red, px.red, 2'b00},
                          {px.green, px.green, 2'b00},
                          {px.blue, px.blue, 2'b00}};  // Widen each channel to 10 bits
        end else begin
            ov_colour <= '0;
        end
    end

    assign overlay = '{valid: ov_valid, start: ov_start, finish: ov_finish, colour: ov_colour};

endmodule

`default_nettype wire

// ==== source/frame_scanner.sv ====
`default_nettype none

module frame_scanner (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            frame_ready,
    output logic                            scan_busy,
    output logic [image_pkg::ADDR_BITS-1:0] scan_addr,
    output image_pkg::scan_tag_t            scan_tag
);

    import image_pkg::*;

    logic                 busy;
    logic [ADDR_BITS-1:0] addr;
    logic [COL_BITS-1:0]  col;  // Tracks addr modulo IMAGE_WIDTH
    logic                 at_first;
    logic                 at_last;

    assign at_first = (addr == '0);
    assign at_last  = (addr == ADDR_BITS'(PIXEL_COUNT - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            addr <= '0;
            col  <= '0;
        end else if (!busy) begin
            // Pulses seen during a sweep fall through to the branches below
            if (frame_ready) begin
                busy <= 1'b1;
                addr <= '0;
                col  <= '0;
            end
        end else if (at_last) begin
            busy <= 1'b0;
        end else begin
            addr <= addr + 1'b1;
            if (col == COL_BITS'(IMAGE_WIDTH - 1)) begin
                col <= '0;  // Wrap to the next row
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assign scan_busy = busy;
    assign scan_addr = addr;

    assign scan_tag = '{
        valid: busy,
        first: busy && at_first,
        last:  busy && at_last,
        col:   col
    };

endmodule

`default_nettype wire

// ==== source/frame_buffer.sv ====
`default_nettype none

module frame_buffer (
    input  logic                            clk,
    input  image_pkg::pixel_write_t         cam_write,
    input  logic [image_pkg::ADDR_BITS-1:0] scan_addr,
    input  image_pkg::scan_tag_t            scan_tag,
    output image_pkg::pixel_beat_t          pixel_beat
);

    import image_pkg::*;

    logic [PIXEL_BITS-1:0] mem [PIXEL_COUNT];
    logic [PIXEL_BITS-1:0] rd_data;
    scan_tag_t             tag_q;

    // Simple dual port RAM, read before write on a shared address
    always_ff @(posedge clk) begin
        if (cam_write.strobe) begin
            mem[cam_write.addr] <= cam_write.pixel;
        end
        rd_data <= mem[scan_addr];
    end

    // Tag follows the read by one cycle so it lines up with rd_data
    always_ff @(posedge clk) begin
        tag_q <= scan_tag;
    end

    assign pixel_beat = '{tag: tag_q, pixel: rgb444_t'(rd_data)};

endmodule

`default_nettype wire

// ==== source/heading_pkg.sv ====
`default_nettype none

package heading_pkg;

    import image_pkg::*;

    localparam int FOV_DEGREES    = 25;  // Horizontal field of view of the camera
    localparam int MIN_RED_PIXELS = 4;
    localparam int HEADING_BITS   = 5;

    // Worst case is every pixel red, each row adding 0 + 1 + ... + (W-1)
    localparam int SUM_BITS =
        $clog2(IMAGE_HEIGHT * (IMAGE_WIDTH * (IMAGE_WIDTH - 1) / 2) + 1);

    typedef struct packed {
        logic [HEADING_BITS-1:0] heading;
        logic                    no_red;
        logic [ADDR_BITS-1:0]    red_count;
    } frame_result_t;

    typedef struct packed {
        logic            valid;
        logic            start;
        logic            finish;
        logic [2:0][9:0] colour;  // Red, green, blue from the top
    } overlay_beat_t;

endpackage

`default_nettype wire

// ==== source/image_pkg.sv ====
`default_nettype none

package image_pkg;

    // Frame geometry, reduced for simulation
    localparam int IMAGE_WIDTH  = 16;
    localparam int IMAGE_HEIGHT = 12;
    localparam int PIXEL_COUNT  = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int ADDR_BITS    = $clog2(PIXEL_COUNT);
    localparam int COL_BITS     = $clog2(IMAGE_WIDTH);

    localparam int PIXEL_BITS    = 12;
    localparam int RED_THRESHOLD = 3;  // Margin red must hold over green and blue

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    // Camera side write into the frame buffer
    typedef struct packed {
        logic                 strobe;
        logic [ADDR_BITS-1:0] addr;
        rgb444_t              pixel;
    } pixel_write_t;

    typedef struct packed {
        logic                valid;
        logic                first;  // Pixel 0 of the frame
        logic                last;   // Final pixel of the frame
        logic [COL_BITS-1:0] col;
    } scan_tag_t;

    typedef struct packed {
        scan_tag_t tag;
        rgb444_t   pixel;
    } pixel_beat_t;

endpackage

`default_nettype wire
